// File: design/robot_io_pkg.sv
package robot_io_pkg;

  // ====================
  // shared vector types
  // ====================
  typedef logic [1:0]         key_t;        // two push buttons
  typedef logic signed [31:0] enc_count_t;  // signed encoder position
  typedef logic [27:0]        prescale_t;   // prescaler terminal count
  typedef logic [2:0]         reset_req_t;  // bit 0 cold, 1 warm, 2 debug

  // encoder phase, encoding is the {a, b} channel pair
  // forward order 00 -> 10 -> 11 -> 01 -> 00
  typedef enum logic [1:0]
  {
    phase_00 = 2'b00,
    phase_10 = 2'b10,
    phase_11 = 2'b11,
    phase_01 = 2'b01
  } quad_phase_e;

  // reset request stretcher
  typedef enum logic
  {
    stretch_idle = 1'b0,
    stretch_busy = 1'b1
  } stretch_state_e;

  // ====================
  // default timing, in fpga_clk_50 cycles
  // ====================
  localparam int unsigned key_debounce_cycles_default = 50000;    // 1 ms
  localparam int unsigned enc_debounce_cycles_default = 500;      // 10 us
  localparam int unsigned heartbeat_cycles_default    = 25000000; // led half period, 0.5 s

  // pulse widths of the reset requests
  localparam int unsigned cold_pulse_cycles_default  = 6;
  localparam int unsigned warm_pulse_cycles_default  = 2;
  localparam int unsigned debug_pulse_cycles_default = 32;

endpackage

// File: design/input_debounce.sv
`timescale 1ns/100ps

module input_debounce
#(
  parameter int unsigned width           = 2,
  parameter int unsigned debounce_cycles = 16,
  parameter bit          invert          = 1'b0  // set for active-low inputs
)
(
  input  logic             fpga_clk_50,
  input  logic             hps_fpga_reset_n,
  input  logic [width-1:0] raw,
  output logic [width-1:0] clean
);

  // room for a count up to debounce_cycles
  localparam int cnt_w = $clog2(debounce_cycles + 1);

  logic [width-1:0] level;       // raw, polarity fixed
  logic [width-1:0] sync_1;
  logic [width-1:0] sync_2;
  logic [cnt_w-1:0] hold_cnt [width];

  // low key reads as pressed when inverted
  assign level = invert ? ~raw : raw;

  // ====================
  // two flop synchronizer
  // ====================
  always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
  begin
    if (!hps_fpga_reset_n)
    begin
      sync_1 <= '0;
      sync_2 <= '0;
    end
    else
    begin
      sync_1 <= level;
      sync_2 <= sync_1;
    end
  end

  // ====================
  // per bit hold counters
  // ====================
  always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
  begin
    if (!hps_fpga_reset_n)
    begin
      clean <= '0;  // released / low
      for (int i = 0; i < width; i++)
        hold_cnt[i] <= '0;
    end
    else
    begin
      for (int i = 0; i < width; i++)
      begin
        if (sync_2[i] == clean[i])
          hold_cnt[i] <= '0;                    // stable, restart
        else if (hold_cnt[i] == cnt_w'(debounce_cycles - 1))
        begin
          clean[i]    <= sync_2[i];             // held long enough, take it
          hold_cnt[i] <= '0;
        end
        else
          hold_cnt[i] <= hold_cnt[i] + cnt_w'(1);
      end
    end
  end

endmodule

// File: design/quadrature_counter.sv
`timescale 1ns/100ps

module quadrature_counter
(
  input  logic                    fpga_clk_50,
  input  logic                    hps_fpga_reset_n,
  input  logic                    a,      // debounced channel a
  input  logic                    b,      // debounced channel b
  input  logic                    clear,  // hold count at zero
  output robot_io_pkg::enc_count_t count
);

  import robot_io_pkg::*;

  quad_phase_e phase;       // last phase seen
  quad_phase_e pair;        // incoming phase
  quad_phase_e phase_fwd;   // one step forward of phase
  quad_phase_e phase_rev;   // one step back

  assign pair = quad_phase_e'({a, b});

  // neighbours of the stored phase
  always_comb
  begin
    case (phase)
      phase_00:
      begin
        phase_fwd = phase_10;
        phase_rev = phase_01;
      end
      phase_10:
      begin
        phase_fwd = phase_11;
        phase_rev = phase_00;
      end
      phase_11:
      begin
        phase_fwd = phase_01;
        phase_rev = phase_10;
      end
      default:  // phase_01
      begin
        phase_fwd = phase_00;
        phase_rev = phase_11;
      end
    endcase
  end

  // ====================
  // position count
  // ====================
  always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
  begin
    if (!hps_fpga_reset_n)
    begin
      phase <= phase_00;
      count <= '0;
    end
    else if (clear)
    begin
      phase <= pair;  // restart from where the shaft sits
      count <= '0;
    end
    else
    begin
      phase <= pair;                                    // double jumps only resync phase
      if (pair == phase_fwd)
        count <= count + 32'sd1;
      else if (pair == phase_rev)
        count <= count - 32'sd1;
    end
  end

endmodule

// File: design/clock_prescaler.sv
`timescale 1ns/100ps

module clock_prescaler
(
  input  logic                   fpga_clk_50,
  input  logic                   hps_fpga_reset_n,
  input  robot_io_pkg::prescale_t prescale_count,  // from software
  input  logic                   clear,
  output logic                   clk_scaled
);

  import robot_io_pkg::*;

  prescale_t cnt;   // cycles into the half period
  prescale_t term;  // terminal count of the running half period

  // toggles every term+1 cycles
  always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
  begin
    if (!hps_fpga_reset_n)
    begin
      cnt        <= '0;
      term       <= '0;
      clk_scaled <= 1'b0;
    end
    else if (clear)
    begin
      cnt        <= '0;
      term       <= prescale_count;
      clk_scaled <= 1'b0;  // parked low
    end
    else if (cnt == term)
    begin
      cnt        <= '0;
      term       <= prescale_count;  // new value only at a wrap
      clk_scaled <= ~clk_scaled;
    end
    else
      cnt <= cnt + 28'd1;
  end

endmodule

// File: design/reset_pulse_stretcher.sv
`timescale 1ns/100ps

module reset_pulse_stretcher
#(
  parameter int unsigned pulse_cycles = 6
)
(
  input  logic fpga_clk_50,
  input  logic hps_fpga_reset_n,
  input  logic req,    // reset request level
  output logic pulse   // fixed width request pulse
);

  import robot_io_pkg::*;

  localparam int cnt_w = $clog2(pulse_cycles + 1);

  logic           req_q;
  logic           rise;
  stretch_state_e state;
  logic [cnt_w-1:0] remain;  // busy cycles left

  assign rise = req & ~req_q;

  // ====================
  // edge detect and fsm
  // ====================
  always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
  begin
    if (!hps_fpga_reset_n)
    begin
      req_q  <= 1'b0;
      state  <= stretch_idle;
      remain <= '0;
      pulse  <= 1'b0;
    end
    else
    begin
      req_q <= req;
      pulse <= (state == stretch_busy);  // output lags state by one
      case (state)
        stretch_idle:
          if (rise)
          begin
            state  <= stretch_busy;
            remain <= cnt_w'(pulse_cycles);
          end
        default:  // busy, edges locked out
        begin
          remain <= remain - cnt_w'(1);
          if (remain == cnt_w'(1))
            state <= stretch_idle;
        end
      endcase
    end
  end

endmodule

// File: design/heartbeat_led.sv
`timescale 1ns/100ps

module heartbeat_led
#(
  parameter int unsigned heartbeat_cycles = 25000000  // half period
)
(
  input  logic fpga_clk_50,
  input  logic hps_fpga_reset_n,
  output logic led
);

  localparam int cnt_w = $clog2(heartbeat_cycles + 1);

  logic [cnt_w-1:0] cnt;

  // free running, flip led on wrap
  always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
  begin
    if (!hps_fpga_reset_n)
    begin
      cnt <= '0;
      led <= 1'b0;
    end
    else if (cnt == cnt_w'(heartbeat_cycles - 1))
    begin
      cnt <= '0;
      led <= ~led;
    end
    else
      cnt <= cnt + cnt_w'(1);
  end

endmodule

// File: design/robot_io_top.sv
`timescale 1ns/100ps

module robot_io_top
#(
  parameter int unsigned key_debounce_cycles = robot_io_pkg::key_debounce_cycles_default,
  parameter int unsigned enc_debounce_cycles = robot_io_pkg::enc_debounce_cycles_default,
  parameter int unsigned heartbeat_cycles    = robot_io_pkg::heartbeat_cycles_default,
  parameter int unsigned cold_pulse_cycles   = robot_io_pkg::cold_pulse_cycles_default,
  parameter int unsigned warm_pulse_cycles   = robot_io_pkg::warm_pulse_cycles_default,
  parameter int unsigned debug_pulse_cycles  = robot_io_pkg::debug_pulse_cycles_default
)
(
  input  logic                     fpga_clk_50,
  input  logic                     hps_fpga_reset_n,
  input  robot_io_pkg::key_t        key,             // active low buttons
  input  logic                     enc_a,
  input  logic                     enc_b,
  input  robot_io_pkg::prescale_t   prescale_count,
  input  robot_io_pkg::reset_req_t  hps_reset_req,
  output robot_io_pkg::key_t        debounced_keys,  // high = pressed
  output robot_io_pkg::enc_count_t  enc_count,
  output logic                     clk_scaled,
  output logic                     cold_reset_req,
  output logic                     warm_reset_req,
  output logic                     debug_reset_req,
  output logic                     led_heartbeat
);

  logic [1:0] enc_clean;  // {a, b} after debounce

  // ====================
  // input conditioning
  // ====================
  input_debounce #(
    .width           (2),
    .debounce_cycles (key_debounce_cycles),
    .invert          (1'b1)
  ) key_debounce (
    .fpga_clk_50      (fpga_clk_50),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .raw              (key),
    .clean            (debounced_keys)
  );

  input_debounce #(
    .width           (2),
    .debounce_cycles (enc_debounce_cycles),
    .invert          (1'b0)
  ) enc_debounce (
    .fpga_clk_50      (fpga_clk_50),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .raw              ({enc_a, enc_b}),
    .clean            (enc_clean)
  );

  // ====================
  // encoder and prescaler, key 0 clears both
  // ====================
  quadrature_counter quad_count (
    .fpga_clk_50      (fpga_clk_50),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .a                (enc_clean[1]),
    .b                (enc_clean[0]),
    .clear            (debounced_keys[0]),
    .count            (enc_count)
  );

  clock_prescaler prescaler (
    .fpga_clk_50      (fpga_clk_50),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .prescale_count   (prescale_count),
    .clear            (debounced_keys[0]),
    .clk_scaled       (clk_scaled)
  );

  // ====================
  // reset request pulses
  // ====================
  reset_pulse_stretcher #(.pulse_cycles(cold_pulse_cycles)) cold_stretch (
    .fpga_clk_50      (fpga_clk_50),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .req              (hps_reset_req[0]),
    .pulse            (cold_reset_req)
  );

  reset_pulse_stretcher #(.pulse_cycles(warm_pulse_cycles)) warm_stretch (
    .fpga_clk_50      (fpga_clk_50),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .req              (hps_reset_req[1]),
    .pulse            (warm_reset_req)
  );

  reset_pulse_stretcher #(.pulse_cycles(debug_pulse_cycles)) debug_stretch (
    .fpga_clk_50      (fpga_clk_50),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .req              (hps_reset_req[2]),
    .pulse            (debug_reset_req)
  );

  heartbeat_led #(.heartbeat_cycles(heartbeat_cycles)) heartbeat (
    .fpga_clk_50      (fpga_clk_50),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .led              (led_heartbeat)
  );

endmodule

// File: sim/tb_robot_io.sv
`timescale 1ns/100ps

module tb_robot_io;

  import robot_io_pkg::*;

  localparam int clk_period   = 100;             // ns
  localparam int key_limit    = 20;              // 16 cycle debounce plus sync
  localparam int toggle_limit = 40;
  localparam int step_hold    = 8;               // cycles per encoder phase

  // ====================
  // watchdog budget, worst case cycles per test
  // ====================
  localparam int beat_budget   = 5 * toggle_limit;
  localparam int key_budget    = 2 * 16 + 2 * 24 + 3 * key_limit;
  localparam int enc_budget    = (16 + 16 + 2) * step_hold + 4 * 6;
  localparam int clear_budget  = 3 * step_hold + 3 * key_limit + 14;
  localparam int scale_budget  = 6 * toggle_limit + 2;
  localparam int pulse_budget  = 3 * (1 + 5 + 64 + 40 + 4);
  localparam int total_budget  = 5 + beat_budget + key_budget + enc_budget
                               + clear_budget + scale_budget + pulse_budget;
  localparam int watchdog_time = (total_budget + 200) * clk_period;

  logic        fpga_clk_50;
  logic        hps_fpga_reset_n;
  key_t        key;
  logic        enc_a;
  logic        enc_b;
  prescale_t   prescale_count;
  reset_req_t  hps_reset_req;
  key_t        debounced_keys;
  enc_count_t  enc_count;
  logic        clk_scaled;
  logic        cold_reset_req;
  logic        warm_reset_req;
  logic        debug_reset_req;
  logic        led_heartbeat;

  logic [31:0] lfsr_state;      // random source
  int          enc_phase;       // index into 00,10,11,01
  int          expected_count;  // model of the position

  robot_io_top #(
    .key_debounce_cycles (16),
    .enc_debounce_cycles (4),
    .heartbeat_cycles    (10),
    .cold_pulse_cycles   (6),
    .warm_pulse_cycles   (2),
    .debug_pulse_cycles  (32)
  ) DUT (
    .fpga_clk_50      (fpga_clk_50),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .key              (key),
    .enc_a            (enc_a),
    .enc_b            (enc_b),
    .prescale_count   (prescale_count),
    .hps_reset_req    (hps_reset_req),
    .debounced_keys   (debounced_keys),
    .enc_count        (enc_count),
    .clk_scaled       (clk_scaled),
    .cold_reset_req   (cold_reset_req),
    .warm_reset_req   (warm_reset_req),
    .debug_reset_req  (debug_reset_req),
    .led_heartbeat    (led_heartbeat)
  );

  initial
  begin
    fpga_clk_50 = 1'b0;
    forever #(clk_period / 2) fpga_clk_50 = ~fpga_clk_50;
  end

  // ====================
  // helpers
  // ====================
  task automatic abort_run(input string why);
    $display("%s", why);
    $display("*** TEST FAILED ***");
    $fatal(1, "run stopped");
  endtask

  task automatic compare(input logic [31:0] actual, input logic [31:0] expected,
                         input string what);
    if (actual !== expected)
      abort_run($sformatf("Error at %0d ns: %s, got 'h%0h expected 'h%0h",
                          $time, what, actual, expected));
  endtask

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic take_random(input int nbits, output int value);
    value = 0;
    for (int i = 0; i < nbits; i++)
    begin
      lfsr_state = lfsr_next(lfsr_state);  // one step per bit
      value      = (value << 1) | lfsr_state[0];
    end
  endtask

  // forward order of the {a, b} pair
  function automatic logic [1:0] phase_bits(input int idx);
    case (idx % 4)
      0:       return 2'b00;
      1:       return 2'b10;
      2:       return 2'b11;
      default: return 2'b01;
    endcase
  endfunction

  function automatic logic read_signal(input int which);
    case (which)
      0:       return clk_scaled;
      1:       return led_heartbeat;
      2:       return cold_reset_req;
      3:       return warm_reset_req;
      default: return debug_reset_req;
    endcase
  endfunction

  task automatic wait_for_keys(input key_t expected, input string what);
    for (int n = 0; n < key_limit; n++)
    begin
      @(negedge fpga_clk_50);
      if (debounced_keys === expected)
        break;
    end
    compare(debounced_keys, expected, what);  // late or never
  endtask

  task automatic observe_keys(input key_t expected, input string what);
    repeat (24)
    begin
      @(negedge fpga_clk_50);
      compare(debounced_keys, expected, what);
    end
  endtask

  // cycles until the selected output flips
  task automatic wait_for_toggle(input int which, output int cycles);
    logic prev;
    prev = read_signal(which);  // caller sits on a falling edge
    for (cycles = 1; cycles <= toggle_limit; cycles++)
    begin
      @(negedge fpga_clk_50);
      if (read_signal(which) !== prev)
        return;
    end
    abort_run($sformatf("output %0d did not toggle within %0d cycles", which, toggle_limit));
  endtask

  task automatic hold_phase(input int idx);
    @(posedge fpga_clk_50);
    {enc_a, enc_b} <= phase_bits(idx);
    repeat (step_hold - 1) @(posedge fpga_clk_50);
  endtask

  // ====================
  // tests
  // ====================
  task automatic heartbeat_period();
    int n;
    @(negedge fpga_clk_50);
    wait_for_toggle(1, n);  // line up with a flip
    repeat (4)
    begin
      wait_for_toggle(1, n);
      compare(n, 10, "led_heartbeat half period");
    end
  endtask

  task automatic key_glitch_and_hold();
    int glitch;
    take_random(4, glitch);
    glitch = glitch % 15 + 1;                 // 1..15
    @(posedge fpga_clk_50);
    key[1] <= 1'b0;
    repeat (glitch) @(posedge fpga_clk_50);
    key[1] <= 1'b1;
    observe_keys(2'b00, "short key press filtered");
    @(posedge fpga_clk_50);
    key[1] <= 1'b0;                           // real press
    wait_for_keys(2'b10, "key 1 pressed");
    take_random(4, glitch);
    glitch = glitch % 15 + 1;
    @(posedge fpga_clk_50);
    key[1] <= 1'b1;                           // bounce while held
    repeat (glitch) @(posedge fpga_clk_50);
    key[1] <= 1'b0;
    observe_keys(2'b10, "short key release filtered");
    @(posedge fpga_clk_50);
    key[1] <= 1'b1;
    wait_for_keys(2'b00, "key 1 released");
  endtask

  task automatic encoder_steps();
    int steps;
    take_random(4, steps);
    steps = steps + 1;
    for (int i = 0; i < steps; i++)
    begin
      enc_phase = (enc_phase + 1) % 4;
      hold_phase(enc_phase);
    end
    expected_count = expected_count + steps;
    @(negedge fpga_clk_50);
    compare(enc_count, expected_count, "count after forward steps");
    take_random(4, steps);
    steps = steps + 1;
    for (int i = 0; i < steps; i++)
    begin
      enc_phase = (enc_phase + 3) % 4;        // one back
      hold_phase(enc_phase);
    end
    expected_count = expected_count - steps;
    @(negedge fpga_clk_50);
    compare(enc_count, expected_count, "count after reverse steps");
    enc_phase = (enc_phase + 2) % 4;          // both channels at once
    hold_phase(enc_phase);
    @(negedge fpga_clk_50);
    compare(enc_count, expected_count, "count after double jump");
    enc_phase = (enc_phase + 1) % 4;          // resynced from new phase
    hold_phase(enc_phase);
    expected_count = expected_count + 1;
    @(negedge fpga_clk_50);
    compare(enc_count, expected_count, "count after step past jump");
  endtask

  task automatic clear_by_key0();
    if (expected_count == 0)
    begin
      enc_phase = (enc_phase + 1) % 4;
      hold_phase(enc_phase);
      expected_count = 1;
    end
    @(posedge fpga_clk_50);
    key[0] <= 1'b0;
    wait_for_keys(2'b01, "key 0 pressed");
    repeat (2) @(posedge fpga_clk_50);        // clear is one flop behind
    enc_phase = (enc_phase + 1) % 4;          // motion during clear
    hold_phase(enc_phase);
    expected_count = 0;
    repeat (10)
    begin
      @(negedge fpga_clk_50);
      compare(enc_count, 0, "count held by key 0");
      compare(clk_scaled, 0, "clk_scaled held by key 0");
    end
    @(posedge fpga_clk_50);
    key[0] <= 1'b1;
    wait_for_keys(2'b00, "key 0 released");
    @(negedge fpga_clk_50);                   // first edge without clear
    compare(enc_count, expected_count, "count after clear");
  endtask

  task automatic prescaler_intervals();
    int ps;
    int n;
    take_random(3, ps);
    @(posedge fpga_clk_50);
    prescale_count <= prescale_t'(ps);
    @(negedge fpga_clk_50);
    wait_for_toggle(0, n);                    // old half period may finish
    wait_for_toggle(0, n);
    repeat (4)
    begin
      wait_for_toggle(0, n);
      compare(n, ps + 1, "clk_scaled half period");
    end
  endtask

  task automatic reset_request_pulses();
    int width;
    int high;
    for (int i = 0; i < 3; i++)
    begin
      width = (i == 0) ? 6 : (i == 1) ? 2 : 32;
      @(posedge fpga_clk_50);
      hps_reset_req <= 3'b001 << i;
      fork
        begin  // second edge lands while busy
          @(posedge fpga_clk_50);
          hps_reset_req <= 3'b000;
          @(posedge fpga_clk_50);
          hps_reset_req <= 3'b001 << i;
        end
        begin
          for (int n = 0; n < 5; n++)
          begin
            @(negedge fpga_clk_50);
            if (read_signal(i + 2))
              break;
          end
          if (!read_signal(i + 2))
            abort_run($sformatf("reset request %0d gave no pulse", i));
          high = 0;
          while (read_signal(i + 2) && high < 64)
          begin
            high++;
            @(negedge fpga_clk_50);
          end
        end
      join
      compare(high, width, $sformatf("pulse width of reset request %0d", i));
      repeat (40)
      begin
        @(negedge fpga_clk_50);
        compare(read_signal(i + 2), 0, "no second reset pulse");
      end
      @(posedge fpga_clk_50);
      hps_reset_req <= 3'b000;
      repeat (3) @(posedge fpga_clk_50);
    end
  endtask

  // ====================
  // watchdog and main sequence
  // ====================
  initial
  begin
    #(watchdog_time);
    abort_run("watchdog expired before the tests finished");
  end

  initial
  begin
    lfsr_state       = 32'h803a;
    enc_phase        = 0;
    expected_count   = 0;
    hps_fpga_reset_n = 1'b0;
    key              = 2'b11;  // released
    enc_a            = 1'b0;
    enc_b            = 1'b0;
    prescale_count   = prescale_t'(3);
    hps_reset_req    = 3'b000;
    repeat (5) @(posedge fpga_clk_50);
    hps_fpga_reset_n <= 1'b1;
    heartbeat_period();
    key_glitch_and_hold();
    encoder_steps();
    clear_by_key0();
    prescaler_intervals();
    reset_request_pulses();
    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

// File: robot_io.f
design/robot_io_pkg.sv
design/input_debounce.sv
design/quadrature_counter.sv
design/clock_prescaler.sv
design/reset_pulse_stretcher.sv
design/heartbeat_led.sv
design/robot_io_top.sv
sim/tb_robot_io.sv

// File: Bender.yml
package:
  name: robot_io

sources:
  - files:
      - design/robot_io_pkg.sv
      - design/input_debounce.sv
      - design/quadrature_counter.sv
      - design/clock_prescaler.sv
      - design/reset_pulse_stretcher.sv
      - design/heartbeat_led.sv
      - design/robot_io_top.sv
  - target: test
    files:
      - sim/tb_robot_io.sv
